/* src.f */
common/la_disp_pkg.sv
verilog/la_video_timing.sv
verilog/timing_gen_xy.sv
grid/la_grid_display.sv
verilog/la_display_top.sv
sim/tb_la_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_la_display -o tb_la_display
./obj_dir/tb_la_display | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "Simulation ended without a result, see $LOG"
	exit 1
fi
echo "Simulation passed"

/* sim/tb_la_display.sv */
// Directed testbench for la_display_top, compiled as the top module from src.f
module tb_la_display;
	import la_disp_pkg::*;

	// Default geometry of la_display_top
	localparam int H_ACT = 64;
	localparam int H_TOTAL = 64 + 4 + 6 + 6;
	localparam int V_ACT = 40;
	localparam int V_TOTAL = 40 + 1 + 2 + 1;
	localparam int V_SYNC = 2;
	localparam int GX0 = 8;
	localparam int GX1 = 55;
	localparam int GY0 = 4;
	localparam int GY1 = 35;
	localparam int CELL_W = 8;
	localparam int CELL_H = 8;
	localparam int CEN_Y = 20;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	// Tests span about four frames after reset
	localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 2400;

	logic        pclk;
	logic        i_arst_n;
	rgb_t        i_bg_color;
	video_beat_t o_beat;
	video_beat_t cur_beat;
	int          cur_x = 0;
	int          cur_y = -1;
	logic        prev_de = 1'b0;
	rgb_t        frame_buf[$];
	rgb_t        frame_bg;
	integer      seed;
	int          cycle_cnt = 0;

	la_display_top dut_i (
		.i_arst_n   (i_arst_n),
		.pclk       (pclk),
		.i_bg_color (i_bg_color),
		.o_beat     (o_beat)
	);

	initial begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;
	end

	always @(posedge pclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	function automatic rgb_t random_color();
		logic [23:0] word;
		word = 24'($random(seed));
		return word;
	endfunction

	// 0 outside the grid region, 1 grid line, 2 black field
	function automatic int pixel_class(input int x, input int y);
		if (x < GX0 || x > GX1 || y < GY0 || y > GY1) begin
			return 0;
		end
		if (y == GY0 || y == GY1 || x == GX0 || x == GX1 || (y - GY0) % CELL_H == 0
			|| (y % 2 == 1 && (x - GX0) % CELL_W == 0)) begin
			return 1;
		end
		return 2;
	endfunction

	// Expected colour of an active pixel in a frame with background bg
	function automatic rgb_t model_color(input int x, input int y, input rgb_t bg);
		case (pixel_class(x, y))
			0: return bg;
			1: return (y == CEN_Y) ? CENTER_COLOR : GRID_COLOR;
			default: return FIELD_COLOR;
		endcase
	endfunction

	// Output monitor, counts de pixels and lines into cur_x and cur_y
	task automatic advance_cycle();
		@(negedge pclk);
		cur_beat = o_beat;
		if (cur_beat.vs) begin
			cur_y = -1;
		end
		if (cur_beat.de && !prev_de) begin
			cur_x = 0;
			cur_y = cur_y + 1;
		end else if (cur_beat.de) begin
			cur_x = cur_x + 1;
		end
		prev_de = cur_beat.de;
	endtask

	task automatic wait_frame_start();
		advance_cycle();
		while (!(cur_beat.de && cur_x == 0 && cur_y == 0)) begin
			advance_cycle();
		end
	endtask

	// Stores one frame in raster order, optionally changing the background mid-frame
	task automatic capture_frame(input string name, input logic do_change, input rgb_t new_bg);
		frame_buf.delete();
		wait_frame_start();
		while (frame_buf.size() < H_ACT * V_ACT) begin
			if (cur_beat.de) begin
				check_value({name, " pixel position"}, frame_buf.size(), cur_y * H_ACT + cur_x);
				frame_buf.push_back(cur_beat.pixel);
				if (do_change && cur_y == V_ACT / 2 && cur_x == 0) begin
					@(posedge pclk);
					i_bg_color <= new_bg;
				end
			end else begin
				check_value({name, " blank pixel"}, 0, int'(cur_beat.pixel));
			end
			if (frame_buf.size() < H_ACT * V_ACT) begin
				advance_cycle();
			end
		end
	endtask

	task automatic check_class(input string name, input int cls, input rgb_t bg);
		int x;
		int y;
		for (int i = 0; i < H_ACT * V_ACT; i++) begin
			x = i % H_ACT;
			y = i / H_ACT;
			if (pixel_class(x, y) == cls) begin
				check_value($sformatf("%s x=%0d y=%0d", name, x, y),
					int'(model_color(x, y, bg)), int'(frame_buf[i]));
			end
		end
	endtask

	// Scan starts in the front porch, so the controls stay low for most of a line
	task automatic test_reset_idle();
		for (int i = 0; i < 3 + H_ACT; i++) begin
			@(negedge pclk);
			check_value("test_reset_idle", 0, int'({o_beat.hs, o_beat.vs, o_beat.de}));
			// Release after three cycles in reset
			if (i == 2) begin
				@(posedge pclk);
				i_arst_n <= 1'b1;
			end
		end
	endtask

	task automatic test_timing();
		int   run = 0;
		int   lines = 0;
		int   hs_pulses = 0;
		int   vs_pulses = 0;
		int   vs_cycles = 0;
		logic last_de = 1'b0;
		logic last_hs = 1'b0;
		logic last_vs = 1'b0;
		wait_frame_start();
		for (int i = 0; i < FRAME_CYCLES; i++) begin
			if (i > 0) begin
				advance_cycle();
			end
			if (cur_beat.de) begin
				run++;
			end else if (last_de) begin
				check_value($sformatf("test_timing de run of line %0d", lines), H_ACT, run);
				lines++;
				run = 0;
			end
			hs_pulses += int'(cur_beat.hs && !last_hs);
			vs_pulses += int'(cur_beat.vs && !last_vs);
			vs_cycles += int'(cur_beat.vs);
			last_de = cur_beat.de;
			last_hs = cur_beat.hs;
			last_vs = cur_beat.vs;
		end
		check_value("test_timing active lines", V_ACT, lines);
		check_value("test_timing hsync pulses", V_TOTAL, hs_pulses);
		check_value("test_timing vsync pulses", 1, vs_pulses);
		check_value("test_timing vsync cycles", V_SYNC * H_TOTAL, vs_cycles);
	endtask

	// Colour goes in before the first vsync after reset
	task automatic test_passthrough();
		@(posedge pclk);
		frame_bg = random_color();
		i_bg_color <= frame_bg;
		capture_frame("test_passthrough", 1'b0, frame_bg);
		check_class("test_passthrough", 0, frame_bg);
	endtask

	task automatic test_grid_lines();
		check_class("test_grid_lines", 1, frame_bg);
	endtask

	task automatic test_field();
		check_class("test_field", 2, frame_bg);
	endtask

	task automatic test_bg_frame_latch();
		rgb_t old_bg;
		rgb_t new_bg;
		old_bg = frame_bg;
		new_bg = random_color();
		if (new_bg == old_bg) begin
			new_bg.r = ~old_bg.r;
		end
		// Mid-frame change leaves this frame on the old colour
		capture_frame("test_bg_frame_latch", 1'b1, new_bg);
		check_class("test_bg_frame_latch old frame", 0, old_bg);
		frame_bg = new_bg;
		capture_frame("test_bg_frame_latch", 1'b0, new_bg);
		check_class("test_bg_frame_latch new frame", 0, new_bg);
	endtask

	initial begin
		seed = 50;
		i_arst_n = 1'b0;
		i_bg_color = '0;
		cur_beat = '0;
		frame_bg = '0;
		test_reset_idle();
		test_passthrough();
		test_grid_lines();
		test_field();
		test_timing();
		test_bg_frame_latch();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* verilog/la_display_top.sv */
// Display back end top, chains timing, position tracking and grid overlay
module la_display_top #(
	parameter int H_ACTIVE = 64,
	parameter int H_FP     = 4,
	parameter int H_SYNC   = 6,
	parameter int H_BP     = 6,
	parameter int V_ACTIVE = 40,
	parameter int V_FP     = 1,
	parameter int V_SYNC   = 2,
	parameter int V_BP     = 1,
	parameter int GRID_X0  = 8,
	parameter int GRID_X1  = 55,
	parameter int GRID_Y0  = 4,
	parameter int GRID_Y1  = 35,
	parameter int CELL_W   = 8,
	parameter int CELL_H   = 8,
	parameter int CENTER_Y = 20
) (
	input  logic                     i_arst_n,
	input  logic                     pclk,
	input  la_disp_pkg::rgb_t        i_bg_color,
	output la_disp_pkg::video_beat_t o_beat
);
	import la_disp_pkg::*;

	video_beat_t        raw_beat;
	video_beat_t        pos_beat;
	logic [COORD_W-1:0] pos_x;
	logic [COORD_W-1:0] pos_y;

	la_video_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FP     (H_FP),
		.H_SYNC   (H_SYNC),
		.H_BP     (H_BP),
		.V_ACTIVE (V_ACTIVE),
		.V_FP     (V_FP),
		.V_SYNC   (V_SYNC),
		.V_BP     (V_BP)
	) timing_i (
		.i_arst_n   (i_arst_n),
		.pclk       (pclk),
		.i_bg_color (i_bg_color),
		.o_beat     (raw_beat)
	);

	timing_gen_xy xy_i (
		.i_arst_n (i_arst_n),
		.pclk     (pclk),
		.i_beat   (raw_beat),
		.o_beat   (pos_beat),
		.o_x      (pos_x),
		.o_y      (pos_y)
	);

	la_grid_display #(
		.GRID_X0  (GRID_X0),
		.GRID_X1  (GRID_X1),
		.GRID_Y0  (GRID_Y0),
		.GRID_Y1  (GRID_Y1),
		.CELL_W   (CELL_W),
		.CELL_H   (CELL_H),
		.CENTER_Y (CENTER_Y)
	) grid_i (
		.i_arst_n (i_arst_n),
		.pclk     (pclk),
		.i_beat   (pos_beat),
		.i_x      (pos_x),
		.i_y      (pos_y),
		.o_beat   (o_beat)
	);

endmodule

/* grid/la_grid_display.sv */
// Grid overlay, draws border, cell lines and a black field inside the measurement region
module la_grid_display #(
	parameter int GRID_X0  = 442,
	parameter int GRID_X1  = 1465,
	parameter int GRID_Y0  = 60,
	parameter int GRID_Y1  = 1020,
	parameter int CELL_W   = 10,
	parameter int CELL_H   = 120,
	parameter int CENTER_Y = 540
) (
	input  logic                            i_arst_n,
	input  logic                            pclk,
	input  la_disp_pkg::video_beat_t        i_beat,
	input  logic [la_disp_pkg::COORD_W-1:0] i_x,
	input  logic [la_disp_pkg::COORD_W-1:0] i_y,
	output la_disp_pkg::video_beat_t        o_beat
);
	import la_disp_pkg::*;

	localparam int CX_W = (CELL_W > 1) ? $clog2(CELL_W) : 1;
	localparam int CY_W = (CELL_H > 1) ? $clog2(CELL_H) : 1;

	localparam logic [COORD_W-1:0] X0_C  = COORD_W'(GRID_X0);
	localparam logic [COORD_W-1:0] X1_C  = COORD_W'(GRID_X1);
	localparam logic [COORD_W-1:0] Y0_C  = COORD_W'(GRID_Y0);
	localparam logic [COORD_W-1:0] Y1_C  = COORD_W'(GRID_Y1);
	localparam logic [COORD_W-1:0] CEN_C = COORD_W'(CENTER_Y);
	localparam logic [CX_W-1:0]    CX_LAST = CX_W'(CELL_W - 1);
	localparam logic [CY_W-1:0]    CY_LAST = CY_W'(CELL_H - 1);

	logic [CX_W-1:0] cx_q;
	logic [CX_W-1:0] cx_cur;
	logic [CY_W-1:0] cy_q;
	logic [CY_W-1:0] cy_cur;
	logic            in_region;
	logic            is_border;
	logic            is_line;
	rgb_t            line_color;

	assign in_region = i_beat.de && (i_x >= X0_C) && (i_x <= X1_C)
		&& (i_y >= Y0_C) && (i_y <= Y1_C);

	// Phases restart at the left and top region edges
	assign cx_cur = (i_x == X0_C) ? '0 : cx_q;
	assign cy_cur = (i_y == Y0_C) ? '0 : cy_q;

	assign is_border = (i_y == Y0_C) || (i_y == Y1_C) || (i_x == X0_C) || (i_x == X1_C);
	// Solid rows every cell, vertical lines dotted on odd rows
	assign is_line = is_border || (cy_cur == '0) || (i_y[0] && (cx_cur == '0));
	assign line_color = (i_y == CEN_C) ? CENTER_COLOR : GRID_COLOR;

	// Column phase of the next pixel in the region
	always_ff @(posedge pclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cx_q <= '0;
		end else if (in_region) begin
			cx_q <= (cx_cur == CX_LAST) ? '0 : cx_cur + 1'b1;
		end
	end

	// Row phase steps on the last region pixel of each row
	always_ff @(posedge pclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cy_q <= '0;
		end else if (in_region && (i_x == X1_C)) begin
			cy_q <= (cy_cur == CY_LAST) ? '0 : cy_cur + 1'b1;
		end
	end

	always_ff @(posedge pclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_beat <= '0;
		end else begin
			o_beat.hs <= i_beat.hs;
			o_beat.vs <= i_beat.vs;
			o_beat.de <= i_beat.de;
			if (in_region) begin
				o_beat.pixel <= is_line ? line_color : FIELD_COLOR;
			end else begin
				o_beat.pixel <= i_beat.pixel;
			end
		end
	end

endmodule

/* verilog/timing_gen_xy.sv */
// Registers a video beat and tags each active pixel with its x and y position
module timing_gen_xy (
	input  logic                            i_arst_n,
	input  logic                            pclk,
	input  la_disp_pkg::video_beat_t        i_beat,
	output la_disp_pkg::video_beat_t        o_beat,
	output logic [la_disp_pkg::COORD_W-1:0] o_x,
	output logic [la_disp_pkg::COORD_W-1:0] o_y
);
	import la_disp_pkg::*;

	logic [COORD_W-1:0] x_cnt;
	logic [COORD_W-1:0] y_cnt;
	logic               de_fall;

	// o_beat.de is the previous input enable
	assign de_fall = o_beat.de && !i_beat.de;

	// Position of the next incoming active pixel
	always_ff @(posedge pclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			if (i_beat.de) begin
				x_cnt <= x_cnt + 1'b1;
			end else if (de_fall) begin
				x_cnt <= '0;
			end
			// vs wins, the frame restarts at row 0
			if (i_beat.vs) begin
				y_cnt <= '0;
			end else if (de_fall) begin
				y_cnt <= y_cnt + 1'b1;
			end
		end
	end

	// Coordinates only change on active pixels
	always_ff @(posedge pclk) begin
		if (i_beat.de) begin
			o_x <= x_cnt;
			o_y <= y_cnt;
		end
	end

	always_ff @(posedge pclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_beat <= '0;
		end else begin
			o_beat <= i_beat;
		end
	end

endmodule

/* verilog/la_video_timing.sv */
// Video timing generator, drives hs, vs, de and the per-frame background colour
module la_video_timing #(
	parameter int H_ACTIVE = 1920,
	parameter int H_FP     = 88,
	parameter int H_SYNC   = 44,
	parameter int H_BP     = 148,
	parameter int V_ACTIVE = 1080,
	parameter int V_FP     = 4,
	parameter int V_SYNC   = 5,
	parameter int V_BP     = 36
) (
	input  logic                     i_arst_n,
	input  logic                     pclk,
	input  la_disp_pkg::rgb_t        i_bg_color,
	output la_disp_pkg::video_beat_t o_beat
);
	import la_disp_pkg::*;

	localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
	localparam int H_W     = $clog2(H_TOTAL);
	localparam int V_W     = $clog2(V_TOTAL);

	// Window edges in counter width
	localparam logic [H_W-1:0] H_ACT_END  = H_W'(H_ACTIVE);
	localparam logic [H_W-1:0] H_SYNC_BEG = H_W'(H_ACTIVE + H_FP);
	localparam logic [H_W-1:0] H_SYNC_END = H_W'(H_ACTIVE + H_FP + H_SYNC);
	localparam logic [H_W-1:0] H_LAST     = H_W'(H_TOTAL - 1);
	localparam logic [V_W-1:0] V_ACT_END  = V_W'(V_ACTIVE);
	localparam logic [V_W-1:0] V_SYNC_BEG = V_W'(V_ACTIVE + V_FP);
	localparam logic [V_W-1:0] V_SYNC_END = V_W'(V_ACTIVE + V_FP + V_SYNC);
	localparam logic [V_W-1:0] V_LAST     = V_W'(V_TOTAL - 1);

	logic [H_W-1:0] h_cnt;
	logic [V_W-1:0] v_cnt;
	rgb_t           bg_q;
	logic           de_now;
	logic           hs_now;
	logic           vs_now;
	logic           bg_load;

	assign de_now  = (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);
	assign hs_now  = (h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END);
	assign vs_now  = (v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END);
	// First clock of the vertical sync
	assign bg_load = (v_cnt == V_SYNC_BEG) && (h_cnt == '0);

	// Out of reset the scan sits at the start of the vertical front porch
	always_ff @(posedge pclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			h_cnt <= '0;
			v_cnt <= V_ACT_END;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Colour held for the whole following frame
	always_ff @(posedge pclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			bg_q <= '0;
		end else if (bg_load) begin
			bg_q <= i_bg_color;
		end
	end

	always_ff @(posedge pclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_beat <= '0;
		end else begin
			o_beat.hs    <= hs_now;
			o_beat.vs    <= vs_now;
			o_beat.de    <= de_now;
			o_beat.pixel <= de_now ? bg_q : '0;
		end
	end

endmodule

/* common/la_disp_pkg.sv */
// Shared types, coordinate width and overlay colours for the logic-analyzer display path
package la_disp_pkg;

	// Width of the pixel x and y coordinates
	localparam int COORD_W = 12;

	// One 24-bit colour, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// One clock of video, pixel is zero outside de
	typedef struct packed {
		logic hs;
		logic vs;
		logic de;
		rgb_t pixel;
	} video_beat_t;

	// Ordinary grid lines, dark yellow
	localparam rgb_t GRID_COLOR = '{
		r: 8'd100,
		g: 8'd100,
		b: 8'd0
	};

	// Lines on the centre row, gold
	localparam rgb_t CENTER_COLOR = '{
		r: 8'd255,
		g: 8'd215,
		b: 8'd0
	};

	// Background inside the grid region
	localparam rgb_t FIELD_COLOR = '{
		r: 8'd0,
		g: 8'd0,
		b: 8'd0
	};

endpackage
